// File: logic/prtc_pkg.sv
package prtc_pkg;

  // parameter RAM is 256 bytes
  localparam int BRAM_AW = 8;

  // seconds between the 1904 and 1970 epochs
  localparam logic [31:0] EPOCH_OFFSET = 32'd2082844800;

  // command byte as written to the data register before a start step.
  // the clock view covers clock, internal and 100ab RAM commands plus the
  // first byte of an extended RAM command
  typedef union packed {
    struct packed {
      logic       rd;       // direction as coded by software
      logic [2:0] kind;     // 000 clock, 010 ram 100ab, 011 internal/extended
      logic [1:0] sel;      // clock byte or register select
      logic [1:0] tail;     // 01 on all short commands
    } clk;
    // the ram view covers the 0abcd command and the second extended byte
    struct packed {
      logic       rd;
      logic       page;     // set for the low 16 bytes
      logic [3:0] addr_lo;  // abcd
      logic [1:0] tail;
    } ram;
  } prtc_cmd_u;

endpackage

// File: logic/prtc_cmd_seq.sv
module prtc_cmd_seq (
  input  logic                         CLK_14M,
  input  logic                         rst_n,
  input  logic                         cen,
  input  logic                         addr,       // 0 data, 1 control
  input  logic                         rw,         // high for read
  input  logic                         strobe,
  input  logic [7:0]                   din,
  input  logic [7:0]                   bram_rdata,
  input  logic [7:0]                   clk_rdata,
  output logic [7:0]                   dout,
  output logic [prtc_pkg::BRAM_AW-1:0] bram_addr,
  output logic [7:0]                   bram_wdata,
  output logic                         bram_we,
  output logic [1:0]                   clk_sel,
  output logic [7:0]                   clk_wdata,
  output logic                         clk_we
);

  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_WAIT  = 3'd1;  // extended address, second byte pending
  localparam logic [2:0] ST_RAM   = 3'd2;
  localparam logic [2:0] ST_CLOCK = 3'd3;
  localparam logic [2:0] ST_INT   = 3'd4;

  logic [7:0]                   data_q;
  logic [6:0]                   ctrl_q;
  logic [2:0]                   state_q;
  logic [prtc_pkg::BRAM_AW-1:0] tgt_q;     // ram address, clock byte or register
  logic                         wp_q;      // write protect, bit 7 of the register
  logic                         bram_we_q;
  logic                         clk_we_q;
  logic                         strobe_seen_q;

  prtc_pkg::prtc_cmd_u cmd;

  logic       bus_acc;
  logic       wr_data;
  logic       wr_ctrl;
  logic       rd_acc;
  logic       step;
  logic       dec_clock;
  logic       dec_int;
  logic       dec_ram_hi;
  logic       dec_ram_lo;
  logic       dec_ext;
  logic [7:0] rd_byte;

  assign bus_acc = strobe && cen;
  assign wr_data = bus_acc && !addr && !rw;
  assign wr_ctrl = bus_acc && addr && !rw;
  assign rd_acc  = bus_acc && rw;
  assign step    = wr_ctrl && din[7];  // start bit

  assign cmd = data_q;

  // command patterns, mutually exclusive
  assign dec_clock  = (cmd.clk.kind == 3'b000) && (cmd.clk.tail == 2'b01);
  assign dec_int    = !cmd.clk.rd && (cmd.clk.kind == 3'b011) && !cmd.clk.sel[1] &&
                      (cmd.clk.tail == 2'b01);
  assign dec_ram_hi = (cmd.clk.kind == 3'b010) && (cmd.clk.tail == 2'b01);
  assign dec_ram_lo = cmd.ram.page && (cmd.ram.tail == 2'b01);
  assign dec_ext    = (cmd.clk.kind == 3'b011) && cmd.clk.sel[1];

  // byte returned by a read transfer
  always_comb begin
    case (state_q)
      ST_RAM:   rd_byte = bram_rdata;
      ST_CLOCK: rd_byte = clk_rdata;
      ST_INT:   rd_byte = tgt_q[0] ? {wp_q, 7'd0} : 8'h00;  // test reg reads 0
      default:  rd_byte = 8'h00;
    endcase
  end

  always_ff @(posedge CLK_14M or negedge rst_n) begin
    if (!rst_n) begin
      data_q        <= 8'h00;
      ctrl_q        <= 7'd0;
      dout          <= 8'h00;
      state_q       <= ST_IDLE;
      wp_q          <= 1'b0;
      bram_we_q     <= 1'b0;
      clk_we_q      <= 1'b0;
      strobe_seen_q <= 1'b0;
    end else begin
      bram_we_q <= 1'b0;
      clk_we_q  <= 1'b0;
      if (!strobe)
        strobe_seen_q <= 1'b0;
      else if (cen)
        strobe_seen_q <= 1'b1;  // held until strobe drops
      if (rd_acc)
        dout <= addr ? {1'b0, ctrl_q} : data_q;  // busy never set
      if (wr_data)
        data_q <= din;
      if (wr_ctrl)
        ctrl_q <= din[6:0];
      if (step) begin
        case (state_q)
          ST_IDLE: begin
            if (dec_clock)
              state_q <= ST_CLOCK;
            else if (dec_int)
              state_q <= ST_INT;
            else if (dec_ram_hi || dec_ram_lo)
              state_q <= ST_RAM;
            else if (dec_ext)
              state_q <= ST_WAIT;
          end
          ST_WAIT: state_q <= ST_RAM;
          ST_RAM, ST_CLOCK, ST_INT: begin
            state_q <= ST_IDLE;
            // direction comes from bit 6 of this transfer step
            if (din[6])
              data_q <= rd_byte;
            else if (state_q == ST_RAM)
              bram_we_q <= !wp_q;
            else if (state_q == ST_CLOCK)
              clk_we_q <= !wp_q;
            else if (tgt_q[0])
              wp_q <= data_q[7];  // test register takes the write and drops it
          end
          default: state_q <= ST_IDLE;
        endcase
      end
    end
  end

  // target address, loaded on decode and on the extended second byte
  always_ff @(posedge CLK_14M or negedge rst_n) begin
    if (!rst_n) begin
      tgt_q <= '0;
    end else if (step && state_q == ST_IDLE) begin
      if (dec_clock)
        tgt_q <= {6'd0, cmd.clk.sel};
      else if (dec_int)
        tgt_q <= {7'd0, cmd.clk.sel[0]};
      else if (dec_ram_hi)
        tgt_q <= {6'b000100, cmd.clk.sel};  // bytes 0x10 to 0x13
      else if (dec_ram_lo)
        tgt_q <= {4'd0, cmd.ram.addr_lo};
      else if (dec_ext)
        tgt_q[7:5] <= {cmd.clk.sel[0], cmd.clk.tail};
    end else if (step && state_q == ST_WAIT) begin
      tgt_q[4:0] <= {cmd.ram.page, cmd.ram.addr_lo};  // bits 6:2 of second byte
    end
  end

  // write strobes land one edge after the step, data_q is stable by then
  assign bram_addr  = tgt_q;
  assign bram_wdata = data_q;
  assign bram_we    = bram_we_q;
  assign clk_sel    = tgt_q[1:0];
  assign clk_wdata  = data_q;
  assign clk_we     = clk_we_q;

  // a strobe lasts one cen, so the pending write never sees a new data byte
  a_strobe_once: assert property (@(posedge CLK_14M) disable iff (!rst_n)
    (cen && strobe) |-> !strobe_seen_q);

  // no data byte arrives on the edge that writes the target
  a_wdata_stable: assert property (@(posedge CLK_14M) disable iff (!rst_n)
    (bram_we || clk_we) |-> !wr_data);

endmodule

// File: logic/prtc_bram.sv
module prtc_bram (
  input  logic                         CLK_14M,
  input  logic [prtc_pkg::BRAM_AW-1:0] addr,
  input  logic [7:0]                   wdata,
  input  logic                         we,
  output logic [7:0]                   rdata
);

  localparam int DEPTH = 2 ** prtc_pkg::BRAM_AW;

  logic [7:0] mem [DEPTH];

  // powers up blank
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 8'h00;
    end
  end

  always_ff @(posedge CLK_14M) begin
    if (we)
      mem[addr] <= wdata;
  end

  assign rdata = mem[addr];  // async read

  // an unknown address would corrupt an arbitrary byte
  a_addr_known: assert property (@(posedge CLK_14M)
    we |-> !$isunknown(addr));

endmodule

// File: logic/prtc_time_keeper.sv
module prtc_time_keeper #(
  parameter int unsigned TICKS_PER_SEC = 14318181,
  parameter int unsigned TICKS_PER_QTR = 3579545
) (
  input  logic        CLK_14M,
  input  logic        rst_n,
  input  logic [32:0] timestamp,  // unix seconds from the host
  input  logic [1:0]  sel,        // byte of the seconds count
  input  logic [7:0]  wdata,
  input  logic        we,
  output logic [7:0]  rdata,
  output logic        one_sec_irq,
  output logic        qtr_sec_irq
);

  localparam int unsigned MAX_TICKS =
    (TICKS_PER_SEC > TICKS_PER_QTR) ? TICKS_PER_SEC : TICKS_PER_QTR;
  localparam int DIV_W = $clog2(MAX_TICKS + 1);

  logic [31:0] sec_q;
  logic [31:0] seed;

  // only the low 32 bits fit the count after the epoch shift
  assign seed = timestamp[31:0] + prtc_pkg::EPOCH_OFFSET;

  // divider 0 is the second, divider 1 the quarter second
  for (genvar i = 0; i < 2; i++) begin : g_div
    localparam int unsigned LEN = (i == 0) ? TICKS_PER_SEC : TICKS_PER_QTR;

    logic [DIV_W-1:0] cnt_q;
    logic             tick;
    logic             irq_q;

    assign tick = (cnt_q == DIV_W'(LEN));  // period is LEN + 1 cycles

    always_ff @(posedge CLK_14M or negedge rst_n) begin
      if (!rst_n) begin
        cnt_q <= '0;
        irq_q <= 1'b0;
      end else begin
        irq_q <= tick;
        if (tick)
          cnt_q <= '0;
        else
          cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK_14M or negedge rst_n) begin
    if (!rst_n) begin
      sec_q <= 32'd0;
    end else begin
      if (sec_q == 32'd0)
        sec_q <= seed;  // reseed while unset
      else if (g_div[0].tick)
        sec_q <= sec_q + 32'd1;
      // a bus write overrides the increment on the same edge
      if (we)
        sec_q[sel*8 +: 8] <= wdata;
    end
  end

  assign rdata       = sec_q[sel*8 +: 8];
  assign one_sec_irq = g_div[0].irq_q;
  assign qtr_sec_irq = g_div[1].irq_q;

  a_irq_pulse: assert property (@(posedge CLK_14M) disable iff (!rst_n)
    !(one_sec_irq && $past(one_sec_irq)) && !(qtr_sec_irq && $past(qtr_sec_irq)));

endmodule

// File: logic/prtc_top.sv
module prtc_top #(
  parameter int unsigned TICKS_PER_SEC = 14318181,
  parameter int unsigned TICKS_PER_QTR = 3579545
) (
  input  logic        CLK_14M,
  input  logic        rst_n,
  input  logic        cen,
  input  logic        addr,
  input  logic        rw,
  input  logic        strobe,
  input  logic [7:0]  din,
  input  logic [32:0] timestamp,
  output logic [7:0]  dout,
  output logic        one_sec_irq,
  output logic        qtr_sec_irq
);

  logic [prtc_pkg::BRAM_AW-1:0] bram_addr;
  logic [7:0]                   bram_wdata;
  logic [7:0]                   bram_rdata;
  logic                         bram_we;
  logic [1:0]                   clk_sel;
  logic [7:0]                   clk_wdata;
  logic [7:0]                   clk_rdata;
  logic                         clk_we;

  prtc_cmd_seq u_cmd_seq (
    .CLK_14M    (CLK_14M),
    .rst_n      (rst_n),
    .cen        (cen),
    .addr       (addr),
    .rw         (rw),
    .strobe     (strobe),
    .din        (din),
    .bram_rdata (bram_rdata),
    .clk_rdata  (clk_rdata),
    .dout       (dout),
    .bram_addr  (bram_addr),
    .bram_wdata (bram_wdata),
    .bram_we    (bram_we),
    .clk_sel    (clk_sel),
    .clk_wdata  (clk_wdata),
    .clk_we     (clk_we)
  );

  prtc_bram u_bram (
    .CLK_14M (CLK_14M),
    .addr    (bram_addr),
    .wdata   (bram_wdata),
    .we      (bram_we),
    .rdata   (bram_rdata)
  );

  prtc_time_keeper #(
    .TICKS_PER_SEC (TICKS_PER_SEC),
    .TICKS_PER_QTR (TICKS_PER_QTR)
  ) u_time_keeper (
    .CLK_14M     (CLK_14M),
    .rst_n       (rst_n),
    .timestamp   (timestamp),
    .sel         (clk_sel),
    .wdata       (clk_wdata),
    .we          (clk_we),
    .rdata       (clk_rdata),
    .one_sec_irq (one_sec_irq),
    .qtr_sec_irq (qtr_sec_irq)
  );

endmodule

// File: verif/prtc_tb.sv
module prtc_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_VEC    = 256;
  localparam int TPS        = 1000;
  localparam int TPQ        = 250;
  localparam int RUN_CYCLES = 2200;  // irq counting window after reset release

  logic        CLK_14M;
  logic        rst_n;
  logic        cen;
  logic        addr;
  logic        rw;
  logic        strobe;
  logic [7:0]  din;
  logic [32:0] timestamp;
  logic [7:0]  dout;
  logic        one_sec_irq;
  logic        qtr_sec_irq;

  logic [31:0] vec [MAX_VEC];
  logic [31:0] seed_exp;  // expected seconds count right after seeding
  integer      seed;
  int          errs = 0;
  int          test_errs = 0;
  int          cur_test = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          n_one = 0;
  int          n_qtr = 0;
  bit          count_done = 1'b0;
  bit          wd_armed = 1'b0;
  int          wd_cycles = 4000;

  prtc_top #(
    .TICKS_PER_SEC (TPS),
    .TICKS_PER_QTR (TPQ)
  ) u_prtc_top (
    .CLK_14M     (CLK_14M),
    .rst_n       (rst_n),
    .cen         (cen),
    .addr        (addr),
    .rw          (rw),
    .strobe      (strobe),
    .din         (din),
    .timestamp   (timestamp),
    .dout        (dout),
    .one_sec_irq (one_sec_irq),
    .qtr_sec_irq (qtr_sec_irq)
  );

  initial CLK_14M = 1'b0;
  always #10 CLK_14M = ~CLK_14M;

  task automatic report_fail(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    errs++;
    test_errs++;
  endtask

  // one strobe cycle, inputs change on the falling edge
  task automatic bus_access(input logic a, input logic r, input logic [7:0] d);
    @(negedge CLK_14M);
    cen    = 1'b1;
    strobe = 1'b1;
    addr   = a;
    rw     = r;
    din    = d;
    @(negedge CLK_14M);
    cen    = 1'b0;
    strobe = 1'b0;
    rw     = 1'b0;
    din    = 8'h00;
  endtask

  task automatic check_read(input logic a, input logic [7:0] exp, input string what);
    bus_access(a, 1'b1, 8'h00);
    // dout was loaded on the access edge, stable at this falling edge
    assert (dout === exp)
    else report_fail($sformatf("%s read %02h, expected %02h", what, dout, exp));
  endtask

  task automatic close_test;
    if (cur_test != 0) begin
      tests_run++;
      if (test_errs != 0)
        tests_failed++;
      $display("test %0d: %s (%0d errors)", cur_test,
               (test_errs == 0) ? "ok" : "bad", test_errs);
    end
    test_errs = 0;
  endtask

  task automatic run_vectors;
    logic [31:0] w;
    logic [7:0]  exp;
    bit          done;
    int          i;
    done = 1'b0;
    i    = 0;
    while (i < MAX_VEC && !done) begin
      w = vec[i];
      case (w[31:28])
        4'h1: bus_access(w[24], 1'b0, w[7:0]);
        4'h2: begin
          if (w[12])
            exp = seed_exp[8*w[9:8] +: 8];  // clock byte of the seed
          else
            exp = w[7:0];
          check_read(w[24], exp, $sformatf("test %0d vector %0d", cur_test, i));
        end
        4'h3: repeat (w[15:0]) @(negedge CLK_14M);
        4'h4: begin
          close_test;
          cur_test = int'(w[7:0]);
        end
        4'hf: done = 1'b1;
        default: begin
          $display("vector %0d has an unknown operation code %h", i, w[31:28]);
          errs++;
          test_errs++;
        end
      endcase
      i++;
    end
  endtask

  initial begin
    seed      = 32'ha813;
    rst_n     = 1'b0;
    cen       = 1'b0;
    strobe    = 1'b0;
    addr      = 1'b0;
    rw        = 1'b0;
    din       = 8'h00;
    timestamp = {1'($random(seed)), 32'($random(seed))};
    seed_exp  = timestamp[31:0] + prtc_pkg::EPOCH_OFFSET;
    for (int i = 0; i < MAX_VEC; i++)
      vec[i] = 32'hf000_0000;  // end marker past the file contents
    $readmemh("verif/prtc_vectors.txt", vec);
    for (int i = 0; i < MAX_VEC; i++) begin
      if (vec[i][31:28] == 4'h3)
        wd_cycles += int'(vec[i][15:0]);
    end
    wd_armed = 1'b1;

    repeat (4) @(posedge CLK_14M);
    @(negedge CLK_14M);
    rst_n = 1'b1;

    run_vectors();
    close_test();

    // irq pulse count over the fixed window
    wait (count_done);
    cur_test = 5;
    assert (n_one == RUN_CYCLES / (TPS + 1))
    else report_fail($sformatf("counted %0d one-second pulses, expected %0d",
                               n_one, RUN_CYCLES / (TPS + 1)));
    assert (n_qtr == RUN_CYCLES / (TPQ + 1))
    else report_fail($sformatf("counted %0d quarter-second pulses, expected %0d",
                               n_qtr, RUN_CYCLES / (TPQ + 1)));
    close_test();

    $display("%0d tests run, %0d tests failed, %0d check errors",
             tests_run, tests_failed, errs);
    if (errs == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // counts cycles with each irq high so a stretched pulse adds to the count
  initial begin
    wait (rst_n);
    repeat (RUN_CYCLES) begin
      @(negedge CLK_14M);
      if (one_sec_irq)
        n_one++;
      if (qtr_sec_irq)
        n_qtr++;
    end
    count_done = 1'b1;
  end

  initial begin
    wait (wd_armed);
    repeat (wd_cycles) @(posedge CLK_14M);
    $display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: verif/prtc_vectors.txt
// op [31:28] 1 write, 2 read and compare, 3 wait [15:0] cycles, 4 start test [7:0], f end
// [24] bus addr (0 data, 1 control), [7:0] data or expected, [12] seed byte [9:8] expected
40000002
// clock bytes 0 to 3 read back the seeded count
10000081 11000080 110000c0 20001000
10000085 11000080 110000c0 20001100
10000089 11000080 110000c0 20001200
1000008d 11000080 110000c0 20001300
40000001
// short command, ram 0x00 <- a5 then read back
10000041 11000080 100000a5 11000080
100000c1 11000080 110000c0 200000a5
// 100ab command, ram 0x12 <- 77
10000029 11000080 10000077 11000080
100000a9 11000080 110000c0 20000077
// extended command, ram 0xff <- e7
1000003f 11000080 1000007c 11000080 100000e7 11000080
1000003f 11000080 1000007c 11000080 110000c0 200000e7
// extended read of unwritten 0xa4
1000003d 11000080 10000010 11000080 110000c0 20000000
// extended read of 0x00 sees the short write
10000038 11000080 10000000 11000080 110000c0 200000a5
// unwritten 0x05 by short command
10000055 11000080 110000c0 20000000
40000006
// control register keeps bits 6:0, busy reads 0
1100003a 2100003a
1100007f 2100007f
40000003
// past the first second pulse
300003e8
10000001 11000080 1000005a 11000080
10000081 11000080 110000c0 2000005a
// past the second pulse
300003e8
10000081 11000080 110000c0 2000005b
40000004
// set write protect and read it back
10000035 11000080 10000080 11000080
10000035 11000080 110000c0 20000080
// protected writes leave old values
10000041 11000080 10000011 11000080
100000c1 11000080 110000c0 200000a5
10000005 11000080 100000a5 11000080
10000085 11000080 110000c0 20001100
// clear protect, writes land again
10000035 11000080 10000000 11000080
10000041 11000080 10000011 11000080
100000c1 11000080 110000c0 20000011
10000005 11000080 100000a5 11000080
10000085 11000080 110000c0 200000a5
f0000000

// File: all.f
logic/prtc_pkg.sv
logic/prtc_cmd_seq.sv
logic/prtc_bram.sv
logic/prtc_time_keeper.sv
logic/prtc_top.sv
verif/prtc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then search the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module prtc_tb -f all.f -o prtc_sim \
  && ./obj_dir/prtc_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTS PASSED" sim.log 2>/dev/null && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }
